// File: vlog.f
rtl/afifo_pkg.sv
rtl/afifo_mem.sv
rtl/afifo_wr_ctrl.sv
rtl/afifo_rd_ctrl.sv
rtl/afifo_top.sv
verification/afifo_gray_chk.sv
verification/afifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the FIFO testbench with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --top-module afifo_tb -f vlog.f -o afifo_sim \
    && ./obj_dir/afifo_sim; } > sim.log 2>&1 \
    || echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && exit 1
exit 0

// File: verification/afifo_tb.sv
`timescale 1ns/1ps

module afifo_tb;

    // Estimated w_clk cycles per test: reset, ordering, full, six levels, recovery
    localparam int TEST_CYCLES = 4 + 160 + 60 + 6 * 50 + 80;
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;
    localparam int LEVELS [6] = '{3, 4, 5, 11, 12, 13};

    logic w_clk = 1'b0;
    logic r_clk = 1'b0;
    logic r_rstn;
    logic wr_en;
    logic rd_en;
    logic full;
    logic almost_full;
    logic empty;
    logic almost_empty;
    afifo_pkg::data_t wr_data;
    afifo_pkg::data_t rd_data;

    // Random source, model of the FIFO contents and traffic counters
    logic [31:0] lfsr_state;
    afifo_pkg::data_t model_q [$];
    string test_name;
    int pushed = 0;
    int popped = 0;
    int w_cycles = 0;

    afifo_top i_dut (.*);

    // Clock periods of 4 ns and 6 ns, so the edges keep sliding past each other
    always #2 w_clk = ~w_clk;
    always #3 r_clk = ~r_clk;

    // Takes count bits from the LFSR, one Galois step per bit
    function automatic afifo_pkg::data_t rand_bits(input int count);
        afifo_pkg::data_t value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
            value = {value[afifo_pkg::DATA_W-2:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Reference model, the next read word is the oldest one accepted
    function automatic afifo_pkg::data_t expected_word();
        return model_q[0];
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            fail_run($sformatf("[ERROR] %s: expected %0h, actual %0h", name, expected, actual));
    endtask

    // Every accepted write goes into the model in the order of acceptance
    always @(posedge w_clk)
    begin
        if (r_rstn && wr_en && !full)
        begin
            model_q.push_back(wr_data);
            pushed++;
        end
    end

    // A pop at this edge has to present the model's oldest word on rd_data
    always @(posedge r_clk)
    begin
        if (r_rstn && rd_en && !empty)
        begin
            if (model_q.size() == 0)
                fail_run("A word was read that was never written");
            check_value(test_name, 32'(expected_word()), 32'(rd_data));
            void'(model_q.pop_front());
            popped++;
        end
    end

    always @(posedge w_clk)
    begin
        w_cycles++;
        if (w_cycles > TIMEOUT_CYCLES)
            fail_run("Timeout: the tests did not finish within the cycle limit");
    end

    // Writes count random words back to back, the FIFO must have room
    task automatic fill_words(input int count);
        @(posedge w_clk);
        #0.5;
        for (int i = 0; i < count; i++)
        begin
            wr_en = 1'b1;
            wr_data = rand_bits(8);
            @(posedge w_clk);
            #0.5;
        end
        wr_en = 1'b0;
    endtask

    // Reads until the model is empty, then lets both synchronizers settle
    task automatic drain_fifo();
        @(posedge r_clk);
        #0.5;
        rd_en = 1'b1;
        while (model_q.size() != 0)
        begin
            @(posedge r_clk);
            #0.5;
        end
        rd_en = 1'b0;
        check_value({test_name, "/drained"}, 1, 32'(empty));
        repeat (4) @(posedge r_clk);
        #0.5;
    endtask

    initial
    begin
        int goal;
        int edges;
        afifo_pkg::data_t single;
        lfsr_state = 32'ha1cb6902;
        r_rstn = 1'b0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        wr_data = '0;
        repeat (2) @(posedge w_clk);
        #0.5;
        r_rstn = 1'b1;

        test_name = "reset";
        check_value("reset/empty", 1, 32'(empty));
        check_value("reset/almost_empty", 1, 32'(almost_empty));
        check_value("reset/full", 0, 32'(full));
        check_value("reset/almost_full", 0, 32'(almost_full));

        // Random enables on both sides until forty words went through
        test_name = "ordering";
        goal = pushed + 40;
        fork
            begin
                fill_words(0);
                while (pushed < goal)
                begin
                    wr_en = rand_bits(1) != '0;
                    wr_data = rand_bits(8);
                    @(posedge w_clk);
                    #0.5;
                end
                wr_en = 1'b0;
            end
            begin
                while (popped < goal)
                begin
                    @(posedge r_clk);
                    #0.5;
                    rd_en = rand_bits(1) != '0;
                end
                rd_en = 1'b0;
            end
        join
        drain_fifo();

        // Sixteen writes fit, full rises at the sixteenth and four are dropped
        test_name = "full";
        fill_words(0);
        for (int i = 0; i < 20; i++)
        begin
            wr_en = 1'b1;
            wr_data = rand_bits(8);
            @(posedge w_clk);
            #0.5;
            check_value("full/rise", 32'(i >= 15), 32'(full));
        end
        wr_en = 1'b0;
        check_value("full/accepted", 16, 32'(model_q.size()));
        drain_fifo();

        test_name = "levels";
        for (int k = 0; k < 6; k++)
        begin
            fill_words(LEVELS[k]);
            repeat (6) @(posedge r_clk);
            #0.5;
            check_value("levels/almost_full",
                        32'(LEVELS[k] >= int'(afifo_pkg::AF_LEVEL)), 32'(almost_full));
            check_value("levels/almost_empty",
                        32'(LEVELS[k] <= int'(afifo_pkg::AE_LEVEL)), 32'(almost_empty));
            drain_fifo();
        end

        // Reads while empty must not move the read pointer
        test_name = "recovery";
        rd_en = 1'b1;
        repeat (4) @(posedge r_clk);
        #0.5;
        rd_en = 1'b0;
        check_value("recovery/idle_empty", 1, 32'(empty));
        fill_words(1);
        single = model_q[0];
        edges = 0;
        while (empty && edges < 3)
        begin
            @(posedge r_clk);
            #0.5;
            edges++;
        end
        check_value("recovery/empty_fall", 0, 32'(empty));
        check_value("recovery/head_word", 32'(single), 32'(rd_data));
        drain_fifo();
        fill_words(16);
        repeat (6) @(posedge r_clk);
        #0.5;
        check_value("recovery/full_before", 1, 32'(full));
        rd_en = 1'b1;
        @(posedge r_clk);
        #0.5;
        rd_en = 1'b0;
        edges = 0;
        while (full && edges < 3)
        begin
            @(posedge w_clk);
            #0.5;
            edges++;
        end
        check_value("recovery/full_fall", 0, 32'(full));
        drain_fifo();

        $display("Everything OK");
        $finish;
    end

endmodule

// File: verification/afifo_gray_chk.sv
`timescale 1ns/1ps

module afifo_gray_chk
(
    input logic            clk,
    input logic            r_rstn,
    input afifo_pkg::ptr_t own_gray,
    input afifo_pkg::ptr_t sync_gray,
    input int              max_sync_bits
);

    // The registered Gray pointer moves by one code step at most per clock
    own_step_a: assert property (@(posedge clk) disable iff (!r_rstn)
        $countones(own_gray ^ $past(own_gray)) <= 1)
        else $error("Gray pointer changed by more than one bit in one clock");

    // While reset is held the pointer has to sit at zero by the next edge
    own_reset_a: assert property (@(posedge clk) !r_rstn |=> own_gray == '0)
        else $error("Gray pointer not at zero during reset");

    // The synchronizer output may only show as many code steps as the other
    // clock can make between two edges of this one
    sync_step_a: assert property (@(posedge clk) disable iff (!r_rstn)
        $countones(sync_gray ^ $past(sync_gray)) <= max_sync_bits)
        else $error("Synchronized Gray pointer jumped by too many bits");

endmodule

// Write side checks its own pointer and the read pointer it receives
bind afifo_wr_ctrl afifo_gray_chk i_gray_chk
    (.clk(w_clk), .r_rstn(r_rstn), .own_gray(wr_gray), .sync_gray(rd_gray_sync),
     .max_sync_bits(1));

// Read side mirrors that with the write pointer.
// The write clock is faster, so two write steps can land between read edges
bind afifo_rd_ctrl afifo_gray_chk i_gray_chk
    (.clk(r_clk), .r_rstn(r_rstn), .own_gray(rd_gray), .sync_gray(wr_gray_sync),
     .max_sync_bits(2));

// File: rtl/afifo_top.sv
`timescale 1ns/1ps

module afifo_top
(
    input  logic              w_clk,
    input  logic              r_clk,
    input  logic              r_rstn,
    input  logic              wr_en,
    input  afifo_pkg::data_t  wr_data,
    output logic              full,
    output logic              almost_full,
    input  logic              rd_en,
    output afifo_pkg::data_t  rd_data,
    output logic              empty,
    output logic              almost_empty
);

    // Write-domain signals towards the storage
    logic             wr_accept;
    afifo_pkg::addr_t wr_addr;

    // Read-domain address into the storage
    afifo_pkg::addr_t rd_addr;

    // Gray pointers, the only signals that cross between the clocks
    afifo_pkg::ptr_t  wr_gray;
    afifo_pkg::ptr_t  rd_gray;

    afifo_mem i_mem
    (
        .w_clk     (w_clk),
        .wr_accept (wr_accept),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // Write side, clocked by w_clk
    afifo_wr_ctrl i_wr_ctrl
    (
        .w_clk       (w_clk),
        .r_rstn      (r_rstn),
        .wr_en       (wr_en),
        .rd_gray     (rd_gray),
        .wr_accept   (wr_accept),
        .wr_addr     (wr_addr),
        .wr_gray     (wr_gray),
        .full        (full),
        .almost_full (almost_full)
    );

    // Read side, clocked by r_clk
    afifo_rd_ctrl i_rd_ctrl
    (
        .r_clk        (r_clk),
        .r_rstn       (r_rstn),
        .rd_en        (rd_en),
        .wr_gray      (wr_gray),
        .rd_addr      (rd_addr),
        .rd_gray      (rd_gray),
        .empty        (empty),
        .almost_empty (almost_empty)
    );

endmodule

// File: rtl/afifo_rd_ctrl.sv
`timescale 1ns/1ps

module afifo_rd_ctrl
(
    input  logic              r_clk,
    input  logic              r_rstn,
    input  logic              rd_en,
    input  afifo_pkg::ptr_t   wr_gray,
    output afifo_pkg::addr_t  rd_addr,
    output afifo_pkg::ptr_t   rd_gray,
    output logic              empty,
    output logic              almost_empty
);

    // Binary read pointer, the low bits select the head entry
    afifo_pkg::ptr_t rd_bin;

    // Pointer values after the current edge
    afifo_pkg::ptr_t rd_bin_next;
    afifo_pkg::ptr_t rd_gray_next;

    // Two-stage synchronizer for the Gray write pointer
    afifo_pkg::ptr_t wr_gray_sync1;
    afifo_pkg::ptr_t wr_gray_sync;

    // Synchronized write pointer in binary and the fill level seen from here
    afifo_pkg::ptr_t wr_bin_sync;
    afifo_pkg::ptr_t rd_fill;

    // A pop happens only when there is a visible word
    logic rd_pop;

    // Flag values to be registered at the next edge
    logic empty_next;
    logic almost_empty_next;

    // Reads while empty are ignored and leave the pointer alone
    assign rd_pop = rd_en && !empty;

    assign rd_addr      = rd_bin[afifo_pkg::ADDR_W-1:0];
    assign rd_bin_next  = rd_bin + afifo_pkg::ptr_t'(rd_pop);
    assign rd_gray_next = afifo_pkg::bin2gray(rd_bin_next);

    // Empty once the next read pointer catches the write pointer
    assign empty_next = (rd_gray_next == wr_gray_sync);

    // Words still visible after this edge, compared against the low threshold
    assign wr_bin_sync       = afifo_pkg::gray2bin(wr_gray_sync);
    assign rd_fill           = wr_bin_sync - rd_bin_next;
    assign almost_empty_next = (rd_fill <= afifo_pkg::AE_LEVEL);

    // Bring the write pointer into this domain through two flops
    always_ff @(posedge r_clk or negedge r_rstn)
    begin
        if (!r_rstn)
        begin
            wr_gray_sync1 <= '0;
            wr_gray_sync  <= '0;
        end
        else
        begin
            wr_gray_sync1 <= wr_gray;
            wr_gray_sync  <= wr_gray_sync1;
        end
    end

    // Binary and Gray read pointers move on each pop
    always_ff @(posedge r_clk or negedge r_rstn)
    begin
        if (!r_rstn)
        begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end
        else
        begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_gray_next;
        end
    end

    // The FIFO starts out empty, so both read-side flags come out of reset high
    always_ff @(posedge r_clk or negedge r_rstn)
    begin
        if (!r_rstn)
        begin
            empty        <= 1'b1;
            almost_empty <= 1'b1;
        end
        else
        begin
            empty        <= empty_next;
            almost_empty <= almost_empty_next;
        end
    end

endmodule

// File: rtl/afifo_wr_ctrl.sv
`timescale 1ns/1ps

module afifo_wr_ctrl
(
    input  logic              w_clk,
    input  logic              r_rstn,
    input  logic              wr_en,
    input  afifo_pkg::ptr_t   rd_gray,
    output logic              wr_accept,
    output afifo_pkg::addr_t  wr_addr,
    output afifo_pkg::ptr_t   wr_gray,
    output logic              full,
    output logic              almost_full
);

    // Binary write pointer, the low bits address the storage
    afifo_pkg::ptr_t wr_bin;

    // Pointer values after the current edge
    afifo_pkg::ptr_t wr_bin_next;
    afifo_pkg::ptr_t wr_gray_next;

    // Two-stage synchronizer for the Gray read pointer
    afifo_pkg::ptr_t rd_gray_sync1;
    afifo_pkg::ptr_t rd_gray_sync;

    // Synchronized read pointer in binary and the fill level seen from here
    afifo_pkg::ptr_t rd_bin_sync;
    afifo_pkg::ptr_t wr_fill;

    // Flag values to be registered at the next edge
    logic full_next;
    logic almost_full_next;

    // A write is taken only while there is room; otherwise it is dropped
    assign wr_accept = wr_en && !full;

    assign wr_addr      = wr_bin[afifo_pkg::ADDR_W-1:0];
    assign wr_bin_next  = wr_bin + afifo_pkg::ptr_t'(wr_accept);
    assign wr_gray_next = afifo_pkg::bin2gray(wr_bin_next);

    // Full when the next write pointer has lapped the read pointer once.
    // In Gray form that means the top two bits differ and the rest match
    assign full_next = (wr_gray_next == {~rd_gray_sync[afifo_pkg::ADDR_W:afifo_pkg::ADDR_W-1],
                                         rd_gray_sync[afifo_pkg::ADDR_W-2:0]});

    // Plain wrap-around difference, the extra pointer bit keeps it unambiguous
    assign rd_bin_sync      = afifo_pkg::gray2bin(rd_gray_sync);
    assign wr_fill          = wr_bin_next - rd_bin_sync;
    assign almost_full_next = (wr_fill >= afifo_pkg::AF_LEVEL);

    // Bring the read pointer into this domain through two flops
    always_ff @(posedge w_clk or negedge r_rstn)
    begin
        if (!r_rstn)
        begin
            rd_gray_sync1 <= '0;
            rd_gray_sync  <= '0;
        end
        else
        begin
            rd_gray_sync1 <= rd_gray;
            rd_gray_sync  <= rd_gray_sync1;
        end
    end

    // Both pointer forms advance together; only the Gray copy leaves the domain
    always_ff @(posedge w_clk or negedge r_rstn)
    begin
        if (!r_rstn)
        begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end
        else
        begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_gray_next;
        end
    end

    // Flags rise at the accepting edge and fall late through the synchronizer
    always_ff @(posedge w_clk or negedge r_rstn)
    begin
        if (!r_rstn)
        begin
            full        <= 1'b0;
            almost_full <= 1'b0;
        end
        else
        begin
            full        <= full_next;
            almost_full <= almost_full_next;
        end
    end

endmodule

// File: rtl/afifo_mem.sv
`timescale 1ns/1ps

module afifo_mem
(
    input  logic              w_clk,
    input  logic              wr_accept,
    input  afifo_pkg::addr_t  wr_addr,
    input  afifo_pkg::data_t  wr_data,
    input  afifo_pkg::addr_t  rd_addr,
    output afifo_pkg::data_t  rd_data
);

    // Storage array shared by both clock domains
    afifo_pkg::data_t mem_array [afifo_pkg::DEPTH];

    // The write port lives in the write domain and only stores accepted words
    always_ff @(posedge w_clk)
    begin
        if (wr_accept)
        begin
            mem_array[wr_addr] <= wr_data;
        end
    end

    // Combinational read port, so the head entry is visible as soon as the
    // read address points at it (first-word fall-through)
    assign rd_data = mem_array[rd_addr];

endmodule

// File: rtl/afifo_pkg.sv
package afifo_pkg;

    // Width of one buffered word
    localparam int DATA_W = 8;

    // Storage address width; the pointers carry one extra wrap bit
    localparam int ADDR_W = 4;

    // Number of storage entries, always a power of two
    localparam int DEPTH = 1 << ADDR_W;

    // One stored word
    typedef logic [DATA_W-1:0] data_t;

    // Storage address
    typedef logic [ADDR_W-1:0] addr_t;

    // Pointer with the extra wrap bit, used for both binary and Gray forms
    typedef logic [ADDR_W:0] ptr_t;

    // Write-side fill level at or above which almost_full is raised
    localparam ptr_t AF_LEVEL = ptr_t'(12);

    // Read-side fill level at or below which almost_empty is raised
    localparam ptr_t AE_LEVEL = ptr_t'(4);

    // Binary to Gray, so that a single increment flips exactly one bit
    function automatic ptr_t bin2gray(input ptr_t bin);
        return (bin >> 1) ^ bin;
    endfunction

    // Gray back to binary, each bit folds in all the Gray bits above it
    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[ADDR_W] = gray[ADDR_W];
        for (int i = ADDR_W - 1; i >= 0; i--)
        begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage
